// ==== logic/ecc_config.svh ====
`ifndef ECC_CONFIG_SVH
`define ECC_CONFIG_SVH

// Data and check widths
`define ECC_DATA_W      84
`define ECC_CHECK_W     8
`define ECC_HAM_W       7   // Hamming part, also codeword position width

// Input buffer entries and starting upstream credits
`define ECC_IN_DEPTH    4

// Starting credits toward downstream
`define ECC_OUT_CREDITS 4

// Occupancy and credit counters, must hold the depth itself
`define ECC_CNT_W       3

`endif

// ==== logic/ecc_pkg.sv ====
`default_nettype none

`include "ecc_config.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0]  ecc_data_t;
    typedef logic [`ECC_CHECK_W-1:0] ecc_check_t;

    // Request as received from upstream
    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t check;
        logic       bypass;
    } ecc_req_t;

    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t syndrome;
        logic       bypass;
    } ecc_synd_t;

    typedef struct packed {
        ecc_data_t data;
        logic      sbit_err;
        logic      dbit_err;
    } ecc_resp_t;

    // Codeword position of data bit idx, skipping powers of two
    function automatic logic [`ECC_HAM_W-1:0] ecc_position(input int unsigned idx);
        int unsigned n;
        logic [`ECC_HAM_W-1:0] pos;
        n = 0;
        pos = '0;
        for (int p = 3; p < (1 << `ECC_HAM_W); p++) begin
            if ((p & (p - 1)) != 0) begin
                if (n == idx) begin
                    pos = p[`ECC_HAM_W-1:0];
                end
                n++;
            end
        end
        return pos;
    endfunction

    // Check bits of a data word
    // Low bits are the Hamming checks, top bit covers even weight positions
    function automatic ecc_check_t ecc_encode(input ecc_data_t data);
        ecc_check_t chk;
        logic [`ECC_HAM_W-1:0] pos;
        chk = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            pos = ecc_position(i);
            for (int k = 0; k < `ECC_HAM_W; k++) begin
                chk[k] = chk[k] ^ (data[i] & pos[k]);
            end
            chk[`ECC_CHECK_W-1] = chk[`ECC_CHECK_W-1] ^ (data[i] & ~^pos);
        end
        return chk;
    endfunction

endpackage

`default_nettype wire

// ==== logic/ecc_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_issue_stage
    import ecc_pkg::*;
(
    input  wire      clk,
    input  wire      rst_n,
    input  wire      in_valid,
    input  ecc_req_t in_req,
    output logic     in_credit,
    input  wire      out_credit,
    output logic     iss_valid,
    output ecc_req_t iss_req
);

    localparam int PTR_W = (`ECC_IN_DEPTH > 1) ? $clog2(`ECC_IN_DEPTH) : 1;
    localparam int CNT_W = `ECC_CNT_W;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ECC_IN_DEPTH - 1);
    localparam logic [CNT_W-1:0] OUT_CREDITS = CNT_W'(`ECC_OUT_CREDITS);

    ecc_req_t         req_mem [`ECC_IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill_cnt;
    logic [CNT_W-1:0] out_cred_cnt;
    logic             pop;

    // Oldest entry leaves only with a downstream credit in hand
    assign pop = (fill_cnt != '0) && (out_cred_cnt != '0);

    assign iss_valid = pop;
    assign iss_req   = req_mem[rd_ptr];
    assign in_credit = pop;     // Freed slot goes back upstream

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_mem[wr_ptr] <= in_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else begin
            case ({in_valid, pop})
                2'b10: begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
                2'b01: begin
                    fill_cnt <= fill_cnt - 1'b1;
                end
                default: begin
                    fill_cnt <= fill_cnt;   // Both or neither
                end
            endcase
        end
    end

    // Downstream credits, reserved at pop time
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cred_cnt <= OUT_CREDITS;
        end else begin
            case ({out_credit, pop})
                2'b10: begin
                    out_cred_cnt <= out_cred_cnt + 1'b1;
                end
                2'b01: begin
                    out_cred_cnt <= out_cred_cnt - 1'b1;
                end
                default: begin
                    out_cred_cnt <= out_cred_cnt;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_syndrome_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       iss_valid,
    input  ecc_req_t  iss_req,
    output logic      syn_valid,
    output ecc_synd_t syn_out
);

    ecc_check_t syndrome;

    // Received check against check recomputed from received data
    assign syndrome = iss_req.check ^ ecc_encode(iss_req.data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            syn_out.data     <= iss_req.data;
            syn_out.syndrome <= syndrome;
            syn_out.bypass   <= iss_req.bypass;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_correct_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       syn_valid,
    input  ecc_synd_t syn_in,
    output logic      out_valid,
    output ecc_resp_t out_resp
);

    ecc_data_t mask;
    logic      no_err;
    logic      check_err;
    logic      data_err;
    ecc_resp_t resp_next;

    // One compare per data bit against that bit's own syndrome
    for (genvar i = 0; i < `ECC_DATA_W; i++) begin : g_mask
        localparam logic [`ECC_HAM_W-1:0] POS = ecc_position(i);
        assign mask[i] = (syn_in.syndrome == {~^POS, POS});
    end

    assign no_err    = (syn_in.syndrome == '0);
    assign data_err  = |mask;
    // Single bit set means a flipped check bit
    assign check_err = !no_err && ((syn_in.syndrome & (syn_in.syndrome - 1'b1)) == '0);

    always_comb begin
        resp_next.data     = syn_in.data;
        resp_next.sbit_err = 1'b0;
        resp_next.dbit_err = 1'b0;
        if (!syn_in.bypass) begin
            if (data_err) begin
                resp_next.data     = syn_in.data ^ mask;
                resp_next.sbit_err = 1'b1;
            end else if (check_err) begin
                resp_next.sbit_err = 1'b1;  // Data already good
            end else if (!no_err) begin
                resp_next.dbit_err = 1'b1;  // Uncorrectable, data as received
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= syn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (syn_valid) begin
            out_resp <= resp_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ecc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_top
    import ecc_pkg::*;
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       in_valid,
    input  ecc_req_t  in_req,
    output logic      in_credit,
    output logic      out_valid,
    output ecc_resp_t out_resp,
    input  wire       out_credit
);

    logic      iss_valid;
    ecc_req_t  iss_req;
    logic      syn_valid;
    ecc_synd_t syn_out;

    // Buffer and credit handling
    ecc_issue_stage issue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_credit (out_credit),
        .iss_valid  (iss_valid),
        .iss_req    (iss_req)
    );

    ecc_syndrome_stage syndrome0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_req   (iss_req),
        .syn_valid (syn_valid),
        .syn_out   (syn_out)
    );

    // Mask, flags and bypass
    ecc_correct_stage correct0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .syn_valid (syn_valid),
        .syn_in    (syn_out),
        .out_valid (out_valid),
        .out_resp  (out_resp)
    );

endmodule

`default_nettype wire

// ==== test/ecc_ref.svh ====
`ifndef ECC_REF_SVH
`define ECC_REF_SVH

// Position of data bit idx, counted over the non powers of two from 3 up
function automatic int ref_position(input int idx);
    int p;
    int seen;
    p = 2;
    seen = -1;
    while (seen < idx) begin
        p++;
        if ($countones(p) != 1) begin
            seen++;
        end
    end
    return p;
endfunction

// Hamming checks in the low bits, top bit over even weight positions
function automatic ecc_check_t ref_encode(input ecc_data_t data);
    ecc_check_t chk;
    int pos;
    chk = '0;
    for (int i = 0; i < `ECC_DATA_W; i++) begin
        if (data[i]) begin
            pos = ref_position(i);
            for (int k = 0; k < `ECC_HAM_W; k++) begin
                if (pos[k]) begin
                    chk[k] = ~chk[k];
                end
            end
            if ($countones(pos) % 2 == 0) begin
                chk[`ECC_CHECK_W-1] = ~chk[`ECC_CHECK_W-1];
            end
        end
    end
    return chk;
endfunction

function automatic ecc_resp_t ref_expected(input ecc_req_t req);
    ecc_resp_t resp;
    ecc_check_t synd;
    ecc_check_t bit_synd;
    int pos;
    bit found;
    resp.data = req.data;
    resp.sbit_err = 1'b0;
    resp.dbit_err = 1'b0;
    synd = req.check ^ ref_encode(req.data);
    found = 1'b0;
    if (!req.bypass && synd != '0) begin
        if ($countones(synd) == 1) begin
            resp.sbit_err = 1'b1;   // Check bit hit, data fine
        end else begin
            for (int i = 0; i < `ECC_DATA_W; i++) begin
                pos = ref_position(i);
                bit_synd = {($countones(pos) % 2 == 0), pos[`ECC_HAM_W-1:0]};
                if (!found && synd == bit_synd) begin
                    resp.data[i] = ~resp.data[i];
                    resp.sbit_err = 1'b1;
                    found = 1'b1;
                end
            end
            if (!found) begin
                resp.dbit_err = 1'b1;
            end
        end
    end
    return resp;
endfunction

`endif

// ==== test/ecc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ecc_config.svh"

module ecc_tb
    import ecc_pkg::*;
();

    localparam int CLK_HALF    = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 300;   // Cycles allowed for any one wait
    localparam int CODE_W      = `ECC_DATA_W + `ECC_CHECK_W;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    ecc_req_t  in_req;
    logic      in_credit;
    logic      out_valid;
    ecc_resp_t out_resp;
    logic      out_credit;

    ecc_resp_t exp_q[$];
    ecc_resp_t exp_resp;
    int        up_credits = `ECC_IN_DEPTH;  // Upstream credits as the driver sees them
    int        pending = 0;                 // Consumed responses not yet credited
    int        received = 0;
    int        checks = 0;
    int        value_errors = 0;
    int        other_errors = 0;
    bit        hold_credits;
    string     test_name;

    ecc_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_resp   (out_resp),
        .out_credit (out_credit)
    );

    `include "ecc_ref.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic check_value(input string name,
                               input logic [$bits(ecc_resp_t)-1:0] expected,
                               input logic [$bits(ecc_resp_t)-1:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic ecc_data_t rand_data();
        logic [95:0] r;
        r = {$urandom(), $urandom(), $urandom()};
        return r[`ECC_DATA_W-1:0];
    endfunction

    function automatic ecc_req_t clean_req(input bit bypass);
        ecc_req_t r;
        r.data = rand_data();
        r.check = ref_encode(r.data);
        r.bypass = bypass;
        return r;
    endfunction

    // Index below the data width hits data, above it the check
    function automatic ecc_req_t flip_bit(input ecc_req_t req, input int idx);
        ecc_req_t r;
        r = req;
        if (idx < `ECC_DATA_W) begin
            r.data[idx] = ~r.data[idx];
        end else begin
            r.check[idx - `ECC_DATA_W] = ~r.check[idx - `ECC_DATA_W];
        end
        return r;
    endfunction

    // Called at drive time, returns at drive time
    task automatic send(input ecc_req_t req);
        int waited;
        waited = 0;
        while (up_credits == 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (up_credits == 0) begin
            report_problem("timed out waiting for an upstream credit");
        end else begin
            in_valid = 1'b1;
            in_req = req;
            exp_q.push_back(ref_expected(req));
            @(posedge clk);
            #DRIVE_DELAY;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || pending != 0) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (exp_q.size() != 0 || pending != 0) begin
            report_problem("timed out waiting for outstanding responses and credits");
        end
    endtask

    // Upstream credit bookkeeping
    always @(negedge clk) begin
        if (!rst_n) begin
            up_credits = `ECC_IN_DEPTH;
        end else begin
            if (in_valid && up_credits <= 0) begin
                report_problem("request sent without an upstream credit");
            end
            up_credits = up_credits - (in_valid ? 1 : 0) + (in_credit ? 1 : 0);
            if (up_credits > `ECC_IN_DEPTH) begin
                report_problem("DUT returned more upstream credits than it has slots");
            end
        end
    end

    // Scoreboard
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_credit) begin
                pending--;
            end
            if (out_valid) begin
                received++;
                pending++;
                if (pending > `ECC_OUT_CREDITS) begin
                    report_problem("more responses outstanding than downstream credits");
                end
                if (exp_q.size() == 0) begin
                    report_problem("response arrived with no request outstanding");
                end else begin
                    exp_resp = exp_q.pop_front();
                    check_value(test_name, exp_resp, out_resp);
                end
            end
        end
    end

    // Credit return, randomly late, held off on request
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (rst_n && !hold_credits && pending > 0 && ($urandom() % 4) != 0) begin
                out_credit = 1'b1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    initial begin
        ecc_req_t req;
        int a;
        int b;
        int n;
        int waited;
        void'($urandom(32'hcd8950e3));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        hold_credits = 1'b0;
        test_name = "reset";
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        if (out_valid !== 1'b0 || in_credit !== 1'b0) begin
            report_problem("outputs not idle after reset");
        end

        test_name = "clean";
        repeat (20) send(clean_req(1'b0));
        drain();

        test_name = "data_single";
        send(flip_bit(clean_req(1'b0), 0));
        send(flip_bit(clean_req(1'b0), `ECC_DATA_W - 1));
        repeat (30) begin
            a = $urandom_range(`ECC_DATA_W - 1, 0);
            send(flip_bit(clean_req(1'b0), a));
        end
        drain();

        test_name = "check_single";
        for (int k = 0; k < `ECC_CHECK_W; k++) begin
            send(flip_bit(clean_req(1'b0), `ECC_DATA_W + k));
        end
        drain();

        test_name = "double";
        repeat (40) begin
            a = $urandom_range(CODE_W - 1, 0);
            b = $urandom_range(CODE_W - 2, 0);
            if (b >= a) begin
                b++;    // Keep the two flips distinct
            end
            send(flip_bit(flip_bit(clean_req(1'b0), a), b));
        end
        drain();

        test_name = "bypass";
        repeat (20) begin
            req = clean_req(1'b1);
            n = $urandom_range(2, 0);
            for (int j = 0; j < n; j++) begin
                req = flip_bit(req, $urandom_range(CODE_W - 1, 0));
            end
            send(req);
        end
        drain();

        // Enough to fill the output credits and then the buffer
        test_name = "backpressure";
        hold_credits = 1'b1;
        repeat (`ECC_OUT_CREDITS + `ECC_IN_DEPTH) begin
            req = clean_req($urandom_range(1, 0) == 1);
            send(flip_bit(req, $urandom_range(CODE_W - 1, 0)));
        end
        waited = 0;
        while (pending != `ECC_OUT_CREDITS && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            waited++;
        end
        if (pending != `ECC_OUT_CREDITS) begin
            report_problem("timed out waiting for responses under back-pressure");
        end
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        if (pending != `ECC_OUT_CREDITS || up_credits != 0) begin
            report_problem("credit state wrong while downstream credits were withheld");
        end
        hold_credits = 1'b0;
        drain();

        $display("Checks %0d, responses %0d, value errors %0d, other errors %0d",
                 checks, received, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && checks > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
+incdir+test
logic/ecc_pkg.sv
logic/ecc_issue_stage.sv
logic/ecc_syndrome_stage.sv
logic/ecc_correct_stage.sv
logic/ecc_top.sv
test/ecc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ECC decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f flist.f --top-module ecc_tb -o ecc_sim

sim_out=$(./obj_dir/ecc_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "TB PASSED"; then
    exit 0
else
    exit 1
fi
